// ==== build.f ====
hdl/tm_sch_pkg.sv
hdl/pio_mem_f.sv
hdl/tm_sch_pri_mem1.sv
hdl/pio_decode.sv
hdl/tm_pri_sch.sv
hdl/tm_sch_top.sv
dv/tm_sch_tb.sv

// ==== dv/tm_sch_tb.sv ====
`timescale 1ns/10ps

module tm_sch_tb
        import tm_sch_pkg::*;
();

        localparam int MAX_TESTS = 64;
        localparam int PIO_WAIT  = 2;  // Host gives up on an ack after this many cycles.

        typedef struct {
                int             due;
                logic [127:0]   name;
                logic           valid;
                sch_rsp_t       rsp;
        } sch_exp_t;

        logic           clk;
        logic           rst_n;
        pio_req_t       pio_req;
        pio_rsp_t       pio_rsp;
        logic           sch_req_valid;
        sch_req_t       sch_req;
        logic           sch_rsp_valid;
        sch_rsp_t       sch_rsp;

        logic [127:0]   t_name [MAX_TESTS];
        logic [7:0]     t_op   [MAX_TESTS];
        logic [31:0]    t_arg  [MAX_TESTS];
        logic [31:0]    t_data [MAX_TESTS];
        logic [31:0]    t_exp  [MAX_TESTS];
        logic           t_ack  [MAX_TESTS];
        int             num_tests;

        pri_entry_t     model0   [SCH_DEPTH];   // Expected contents of bank 0.
        logic           written0 [SCH_DEPTH];
        sch_exp_t       exp_q [$];              // Scheduling responses still due.
        int             seed        = 51;
        int             cycle       = 0;
        int             cycle_limit = 1000;
        int             n_tests     = 0;
        int             n_errors    = 0;

        tm_sch_top u_tm_sch_top (
                .clk           (clk),
                .rst_n         (rst_n),
                .pio_req       (pio_req),
                .pio_rsp       (pio_rsp),
                .sch_req_valid (sch_req_valid),
                .sch_req       (sch_req),
                .sch_rsp_valid (sch_rsp_valid),
                .sch_rsp       (sch_rsp)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // ########################################
        // Result reporting and compare tasks
        // ########################################
        task automatic report_pass(input logic [127:0] name);
                n_tests++;
                $display("PASS     %0s", name);
        endtask

        task automatic report_fail(input logic [127:0] name, input string what);
                n_tests++;
                n_errors++;
                $display("FAIL     %0s: %0s", name, what);
        endtask

        task automatic check_pio(input logic [127:0] name, input pio_rsp_t exp, input pio_rsp_t act);
                if (act !== exp) begin
                        n_tests++;
                        n_errors++;
                        $display("Mismatch %0s: expected %h, actual %h", name, exp, act);
                end else begin
                        report_pass(name);
                end
        endtask

        task automatic check_sch(input logic [127:0] name, input sch_rsp_t exp, input sch_rsp_t act);
                if (act !== exp) begin
                        n_tests++;
                        n_errors++;
                        $display("Mismatch %0s: expected %h, actual %h", name, exp, act);
                end else begin
                        report_pass(name);
                end
        endtask

        task automatic check_no_sch(input logic [127:0] name, input logic valid);
                if (valid !== 1'b0) begin
                        report_fail(name, "a scheduling response came for an empty mask");
                end else begin
                        report_pass(name);
                end
        endtask

        // Fixed latency of 2, sampled on the third falling edge after the request edge.
        always @(negedge clk) begin : sch_monitor
                sch_exp_t e;
                cycle++;
                if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
                        e = exp_q.pop_front();
                        if (!e.valid) begin
                                check_no_sch(e.name, sch_rsp_valid);
                        end else if (sch_rsp_valid !== 1'b1) begin
                                report_fail(e.name, "no scheduling response two cycles later");
                        end else begin
                                check_sch(e.name, e.rsp, sch_rsp);
                        end
                end else if (sch_rsp_valid === 1'b1) begin
                        report_fail("sch_monitor", "a scheduling response came with no request");
                end
                if (cycle > cycle_limit) begin
                        $display("Timeout after %0d cycles, the run did not finish.", cycle);
                        $display("CHECKS FAILED");
                        $finish;
                end
        end

        // ########################################
        // Stimulus
        // ########################################
        task automatic drive_idle();
                pio_req.op    <= PIO_IDLE;
                sch_req_valid <= 1'b0;
        endtask

        task automatic drive_pio(input pio_op_e kind, input logic [31:0] addr, input logic [31:0] din);
                pio_req <= '{op: kind, addr: addr, din: din};
        endtask

        task automatic drive_sch(input logic [127:0] name, input logic [SCH_ID_NBITS-1:0] id,
                                 input logic [NUM_PRI-1:0] mask, input sch_rsp_t rsp,
                                 input logic valid);
                sch_exp_t e;
                sch_req_valid <= 1'b1;
                sch_req       <= '{sch_id: id, pri_mask: mask};
                e.due   = cycle + 3;
                e.name  = name;
                e.valid = valid;
                e.rsp   = rsp;
                exp_q.push_back(e);
        endtask

        task automatic wait_pio_rsp(input logic [127:0] name, input logic is_read,
                                    input logic exp_ack, input logic [31:0] exp_rdata);
                int             waited;
                logic           got;
                pio_rsp_t       exp_rsp;
                waited = 0;
                got    = 1'b0;
                while (!got && waited < PIO_WAIT) begin
                        @(posedge clk);
                        drive_idle();
                        @(negedge clk);
                        waited++;
                        got = (pio_rsp.ack === 1'b1);
                end
                if (exp_ack && !got) begin
                        report_fail(name, "no PIO ack within two cycles");
                end else if (!exp_ack && got) begin
                        report_fail(name, "a PIO ack came for an address outside the region");
                end else if (got && waited > 1) begin
                        report_fail(name, "the PIO ack came later than one cycle after the op");
                end else if (got && is_read) begin
                        exp_rsp.ack   = 1'b1;
                        exp_rsp.rdata = exp_rdata;
                        check_pio(name, exp_rsp, pio_rsp);
                end else begin
                        report_pass(name);
                end
        endtask

        task automatic issue_line(input int i);
                logic [SCH_ID_NBITS-1:0] idx;
                idx = t_arg[i][ADDR_IDX_LSB +: SCH_ID_NBITS];
                if (t_op[i] == "S") begin
                        drive_sch(t_name[i], t_arg[i][SCH_ID_NBITS-1:0], t_data[i][NUM_PRI-1:0],
                                  sch_rsp_t'(t_exp[i][$bits(sch_rsp_t)-1:0]), t_ack[i]);
                end else begin
                        drive_pio((t_op[i] == "W") ? PIO_WRITE : PIO_READ, t_arg[i], t_data[i]);
                        if (t_op[i] == "W" && t_arg[i][15:11] == 5'(PRI_CTRL_BASE) &&
                            t_arg[i][10:8] == 3'd0) begin
                                model0[idx]   = pri_entry_t'(t_data[i][ENTRY_NBITS-1:0]);
                                written0[idx] = 1'b1;
                        end
                end
        endtask

        task automatic load_tests();
                int             fd;
                int             cnt;
                logic [8*96-1:0] line;
                logic [31:0]    ack;
                num_tests = 0;
                fd = $fopen("dv/tm_sch_tests.txt", "r");
                if (fd != 0) begin
                        while (!$feof(fd) && num_tests < MAX_TESTS) begin
                                line = '0;
                                cnt  = $fgets(line, fd);
                                cnt  = $sscanf(line, "%s %s %h %h %h %h", t_name[num_tests],
                                               t_op[num_tests], t_arg[num_tests],
                                               t_data[num_tests], t_exp[num_tests], ack);
                                if (cnt == 6) begin     // Comment and blank lines drop out here.
                                        t_ack[num_tests] = ack[0];
                                        num_tests++;
                                end
                        end
                        $fclose(fd);
                end
        endtask

        task automatic run_file_tests();
                int i;
                i = 0;
                while (i < num_tests) begin
                        @(posedge clk);
                        drive_idle();
                        if (t_op[i] == "S") begin
                                issue_line(i);
                                i++;
                                // A PIO op right after a request goes out in the same cycle.
                                if (i < num_tests && t_op[i] != "S") begin
                                        issue_line(i);
                                        wait_pio_rsp(t_name[i], t_op[i] == "R", t_ack[i], t_exp[i]);
                                        i++;
                                end
                        end else begin
                                issue_line(i);
                                wait_pio_rsp(t_name[i], t_op[i] == "R", t_ack[i], t_exp[i]);
                                i++;
                        end
                end
        endtask

        task automatic run_random_tests();
                logic [31:0]    rnd;
                logic [31:0]    addr;
                sch_rsp_t       rsp;
                for (int idx = 0; idx < SCH_DEPTH; idx++) begin
                        if (!written0[idx]) begin
                                rnd         = $random(seed);
                                model0[idx] = pri_entry_t'(rnd[ENTRY_NBITS-1:0]);
                                addr        = {16'h0, 5'(PRI_CTRL_BASE), 3'd0, 6'(idx), 2'b00};
                                @(posedge clk);
                                drive_idle();
                                drive_pio(PIO_WRITE, addr, rnd);
                                wait_pio_rsp("rand_wr", 1'b0, 1'b1, '0);
                        end
                end
                // Every bank 0 entry back through the scheduling port, one per cycle.
                for (int idx = 0; idx < SCH_DEPTH; idx++) begin
                        rnd       = $random(seed);
                        rsp.pri   = '0;
                        rsp.entry = model0[idx];
                        @(posedge clk);
                        drive_idle();
                        drive_sch("rand_sch", SCH_ID_NBITS'(idx), rnd[NUM_PRI-1:0] | 8'h01, rsp, 1'b1);
                end
                @(posedge clk);
                drive_idle();
        endtask

        // ########################################
        // Main sequence
        // ########################################
        initial begin : main
                rst_n         = 1'b0;
                pio_req       = '0;
                sch_req_valid = 1'b0;
                sch_req       = '0;
                for (int k = 0; k < SCH_DEPTH; k++) begin
                        written0[k] = 1'b0;
                end
                load_tests();
                if (num_tests == 0) begin
                        $display("No test vectors could be read from dv/tm_sch_tests.txt.");
                        $display("CHECKS FAILED");
                        $finish;
                end else begin
                        cycle_limit = 10 * (num_tests + 2 * SCH_DEPTH) + 100;
                        repeat (10) @(posedge clk);
                        rst_n <= 1'b1;
                        run_file_tests();
                        run_random_tests();
                        while (exp_q.size() != 0) begin
                                @(posedge clk);
                        end
                        repeat (2) @(posedge clk);
                        $display("Tests run: %0d, failed: %0d", n_tests, n_errors);
                        if (n_errors == 0) begin
                                $display("ALL CHECKS PASSED");
                        end else begin
                                $display("CHECKS FAILED");
                        end
                        $finish;
                end
        end

endmodule

// ==== dv/tm_sch_tests.txt ====
# columns: name op arg data expected ack, all numbers in hex
# W lines: arg is the PIO address, data is din, ack is 1 when an ack is due
# R lines: arg is the PIO address, expected is rdata
# S lines: arg is sch_id, data is pri_mask, expected is {pri,entry}, ack is response valid
wr_b0_i5   W 0814 0000a1b2 0        1
rd_b0_i5   R 0814 0        0000a1b2 1
wr_b3_i5   W 0b14 ffff3c4d 0        1
wr_b7_i5   W 0f14 00007e8f 0        1
rd_b3_i5   R 0b14 0        00003c4d 1
rd_b7_i5   R 0f14 0        00007e8f 1
rd_b0_i5b  R 0814 0        0000a1b2 1
wr_b3_i9   W 0b24 00001122 0        1
wr_b5_i9   W 0d24 00005566 0        1
rd_b5_i9   R 0d24 0        00005566 1
wr_out     W 1314 0000dead 0        0
rd_out     R 1314 0        0        0
rd_b3_chk  R 0b14 0        00003c4d 1
wr_out2    W 0014 0000beef 0        0
rd_b0_chk  R 0814 0        0000a1b2 1
sch_m01    S 05   01       0a1b2    1
sch_m08    S 05   f8       33c4d    1
sch_m80    S 05   80       77e8f    1
sch_m28    S 09   28       31122    1
sch_m20    S 09   20       55566    1
sch_none   S 09   00       0        0
sch_par1   S 05   18       33c4d    1
rd_par1    R 0f14 0        00007e8f 1
sch_par2   S 09   a0       55566    1
rd_par2    R 0b24 0        00001122 1

// ==== hdl/pio_decode.sv ====
`timescale 1ns/10ps

module pio_decode
        import tm_sch_pkg::*;
(
        input  logic                                    clk,
        input  logic                                    rst_n,

        input  pio_req_t                                pio_req,
        output logic [NUM_PRI-1:0]                      reg_ms,

        input  logic [NUM_PRI-1:0]                      mem_ack,
        input  logic [NUM_PRI-1:0][PIO_NBITS-1:0]       mem_rdata,
        output pio_rsp_t                                pio_rsp
);

        logic                           region_hit;
        logic [PRI_NBITS-1:0]           bank;
        logic [NUM_PRI-1:0]             pend_ms;        // Banks selected last cycle.
        logic [NUM_PRI-1:0]             ack_ok;

        assign region_hit = pio_req.addr[ADDR_REGION_LSB +: ADDR_REGION_NBITS] ==
                            ADDR_REGION_NBITS'(PRI_CTRL_BASE);
        assign bank       = pio_req.addr[ADDR_BANK_LSB +: PRI_NBITS];

        always_comb begin
                reg_ms = '0;
                if (region_hit && (pio_req.op != PIO_IDLE)) begin
                        reg_ms[bank] = 1'b1;    // One-hot bank select.
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        pend_ms <= '0;
                end else begin
                        pend_ms <= reg_ms;
                end
        end

        // Only an ack from the bank we selected counts.
        assign ack_ok = mem_ack & pend_ms;

        always_comb begin
                pio_rsp.ack   = |ack_ok;
                pio_rsp.rdata = '0;
                for (int i = 0; i < NUM_PRI; i++) begin
                        pio_rsp.rdata = pio_rsp.rdata | (mem_rdata[i] & {PIO_NBITS{ack_ok[i]}});
                end
        end

endmodule

// ==== hdl/pio_mem_f.sv ====
`timescale 1ns/10ps

module pio_mem_f
        import tm_sch_pkg::*;
(
        input  logic                    clk,
        input  logic                    rst_n,

        input  pio_req_t                pio_req,
        input  logic                    reg_ms,

        input  logic                    wr,
        input  logic [SCH_ID_NBITS-1:0] waddr,
        input  pri_entry_t              wdata,

        input  logic                    app_rd,
        input  logic [SCH_ID_NBITS-1:0] app_raddr,

        output logic                    mem_ack,
        output logic [PIO_NBITS-1:0]    mem_rdata,

        output logic                    app_ack,
        output pri_entry_t              app_rdata
);

        pri_entry_t                     mem [SCH_DEPTH];
        logic [SCH_ID_NBITS-1:0]        pio_idx;
        logic                           pio_sel;

        assign pio_idx = pio_req.addr[ADDR_IDX_LSB +: SCH_ID_NBITS];
        assign pio_sel = reg_ms && (pio_req.op != PIO_IDLE);

        always_ff @(posedge clk) begin
                if (wr) begin
                        mem[waddr] <= wdata;    // Strobe comes registered from the wrapper.
                end
        end

        // ########################################
        // PIO response, one cycle after the op
        // ########################################
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        mem_ack <= 1'b0;
                end else begin
                        mem_ack <= pio_sel;     // Reads and writes are both acked.
                end
        end

        always_ff @(posedge clk) begin
                if (pio_req.op == PIO_READ) begin
                        mem_rdata <= {{(PIO_NBITS-ENTRY_NBITS){1'b0}}, mem[pio_idx]};
                end else begin
                        mem_rdata <= '0;        // Write acks carry no data.
                end
        end

        // Application read port, independent of PIO traffic
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        app_ack <= 1'b0;
                end else begin
                        app_ack <= app_rd;
                end
        end

        always_ff @(posedge clk) begin
                app_rdata <= mem[app_raddr];
        end

endmodule

// ==== hdl/tm_pri_sch.sv ====
`timescale 1ns/10ps

module tm_pri_sch
        import tm_sch_pkg::*;
(
        input  logic                                    clk,
        input  logic                                    rst_n,

        input  logic                                    sch_req_valid,
        input  sch_req_t                                sch_req,

        output logic [NUM_PRI-1:0]                      app_rd,
        output logic [NUM_PRI-1:0][SCH_ID_NBITS-1:0]    app_raddr,

        input  logic [NUM_PRI-1:0]                      app_ack,
        input  pri_entry_t [NUM_PRI-1:0]                app_rdata,

        output logic                                    sch_rsp_valid,
        output sch_rsp_t                                sch_rsp
);

        logic                           pri_hit;
        logic [PRI_NBITS-1:0]           pri_sel;
        logic [PRI_NBITS-1:0]           pri_d1;         // Chosen priority, bank read cycle.
        logic [PRI_NBITS-1:0]           pri_d2;         // Chosen priority, ack cycle.

        // ########################################
        // Lowest set bit of the mask wins
        // ########################################
        always_comb begin
                pri_hit = 1'b0;
                pri_sel = '0;
                for (int i = NUM_PRI - 1; i >= 0; i--) begin
                        if (sch_req.pri_mask[i]) begin
                                pri_hit = 1'b1;
                                pri_sel = PRI_NBITS'(i);
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        app_rd <= '0;
                end else begin
                        app_rd <= '0;
                        if (sch_req_valid && pri_hit) begin
                                app_rd[pri_sel] <= 1'b1;
                        end
                end
        end

        // All banks see the same index, only one is strobed.
        always_ff @(posedge clk) begin
                for (int i = 0; i < NUM_PRI; i++) begin
                        app_raddr[i] <= sch_req.sch_id;
                end
                pri_d1 <= pri_sel;
                pri_d2 <= pri_d1;
        end

        // ########################################
        // Response, two cycles after the request
        // ########################################
        assign sch_rsp_valid = |app_ack;
        assign sch_rsp.pri   = pri_d2;
        assign sch_rsp.entry = app_rdata[pri_d2];

endmodule

// ==== hdl/tm_sch_pkg.sv ====
package tm_sch_pkg;

        // ########################################
        // Widths
        // ########################################
        localparam int PIO_NBITS       = 32;                   // PIO data and address.
        localparam int QUEUE_ID_NBITS  = 8;                    // One queue id.
        localparam int ENTRY_NBITS     = 2 * QUEUE_ID_NBITS;   // High and low queue.
        localparam int SCH_ID_NBITS    = 6;                    // Scheduler id, memory index.
        localparam int SCH_DEPTH       = 1 << SCH_ID_NBITS;    // Entries per bank.
        localparam int NUM_PRI         = 8;                    // Priority levels, one bank each.
        localparam int PRI_NBITS       = 3;                    // Priority index.

        // ########################################
        // PIO address map
        // ########################################
        localparam int PRI_CTRL_BASE     = 1;  // Region code in addr[15:11].
        localparam int ADDR_REGION_LSB   = 11;
        localparam int ADDR_REGION_NBITS = 5;
        localparam int ADDR_BANK_LSB     = 8;  // Bank is addr[10:8].
        localparam int ADDR_IDX_LSB      = 2;  // Entry index is addr[7:2].

        typedef enum logic [1:0] {
                PIO_IDLE,
                PIO_READ,
                PIO_WRITE
        } pio_op_e;

        typedef struct packed {
                pio_op_e                op;
                logic [PIO_NBITS-1:0]   addr;
                logic [PIO_NBITS-1:0]   din;
        } pio_req_t;

        typedef struct packed {
                logic                   ack;
                logic [PIO_NBITS-1:0]   rdata;
        } pio_rsp_t;

        typedef struct packed {
                logic [QUEUE_ID_NBITS-1:0] queue_hi;
                logic [QUEUE_ID_NBITS-1:0] queue_lo;
        } pri_entry_t;

        typedef struct packed {
                logic [SCH_ID_NBITS-1:0] sch_id;
                logic [NUM_PRI-1:0]      pri_mask; // Bit n set means priority n is active.
        } sch_req_t;

        typedef struct packed {
                logic [PRI_NBITS-1:0]   pri;
                pri_entry_t             entry;
        } sch_rsp_t;

endpackage

// ==== hdl/tm_sch_pri_mem1.sv ====
`timescale 1ns/10ps

module tm_sch_pri_mem1
        import tm_sch_pkg::*;
(
        input  logic                                    clk,
        input  logic                                    rst_n,

        input  pio_req_t                                pio_req,
        input  logic [NUM_PRI-1:0]                      reg_ms,

        input  logic [NUM_PRI-1:0]                      app_rd,
        input  logic [NUM_PRI-1:0][SCH_ID_NBITS-1:0]    app_raddr,

        output logic [NUM_PRI-1:0]                      mem_ack,
        output logic [NUM_PRI-1:0][PIO_NBITS-1:0]       mem_rdata,

        output logic [NUM_PRI-1:0]                      app_ack,
        output pri_entry_t [NUM_PRI-1:0]                app_rdata
);

        logic [NUM_PRI-1:0]             bank_wr;
        logic [SCH_ID_NBITS-1:0]        bank_waddr;
        pri_entry_t                     bank_wdata;

        // ########################################
        // Registered write path
        // ########################################
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        bank_wr <= '0;
                end else begin
                        bank_wr <= reg_ms & {NUM_PRI{pio_req.op == PIO_WRITE}};
                end
        end

        // Index and data are shared, only the strobe is per bank.
        always_ff @(posedge clk) begin
                bank_waddr <= pio_req.addr[ADDR_IDX_LSB +: SCH_ID_NBITS];
                bank_wdata <= pri_entry_t'(pio_req.din[ENTRY_NBITS-1:0]);
        end

        // ########################################
        // One bank per priority level
        // ########################################
        for (genvar i = 0; i < NUM_PRI; i++) begin : g_bank
                pio_mem_f u_pio_mem_f (
                        .clk       (clk),
                        .rst_n     (rst_n),

                        .pio_req   (pio_req),
                        .reg_ms    (reg_ms[i]),

                        .wr        (bank_wr[i]),
                        .waddr     (bank_waddr),
                        .wdata     (bank_wdata),

                        .app_rd    (app_rd[i]),
                        .app_raddr (app_raddr[i]),

                        .mem_ack   (mem_ack[i]),
                        .mem_rdata (mem_rdata[i]),

                        .app_ack   (app_ack[i]),
                        .app_rdata (app_rdata[i])
                );
        end

endmodule

// ==== hdl/tm_sch_top.sv ====
`timescale 1ns/10ps

module tm_sch_top
        import tm_sch_pkg::*;
(
        input  logic            clk,
        input  logic            rst_n,

        input  pio_req_t        pio_req,
        output pio_rsp_t        pio_rsp,

        input  logic            sch_req_valid,
        input  sch_req_t        sch_req,
        output logic            sch_rsp_valid,
        output sch_rsp_t        sch_rsp
);

        logic [NUM_PRI-1:0]                     reg_ms;
        logic [NUM_PRI-1:0]                     mem_ack;
        logic [NUM_PRI-1:0][PIO_NBITS-1:0]      mem_rdata;
        logic [NUM_PRI-1:0]                     app_rd;
        logic [NUM_PRI-1:0][SCH_ID_NBITS-1:0]   app_raddr;
        logic [NUM_PRI-1:0]                     app_ack;
        pri_entry_t [NUM_PRI-1:0]               app_rdata;

        pio_decode u_pio_decode (
                .clk       (clk),
                .rst_n     (rst_n),
                .pio_req   (pio_req),
                .reg_ms    (reg_ms),
                .mem_ack   (mem_ack),
                .mem_rdata (mem_rdata),
                .pio_rsp   (pio_rsp)
        );

        tm_sch_pri_mem1 u_tm_sch_pri_mem1 (
                .clk       (clk),
                .rst_n     (rst_n),
                .pio_req   (pio_req),
                .reg_ms    (reg_ms),
                .app_rd    (app_rd),
                .app_raddr (app_raddr),
                .mem_ack   (mem_ack),
                .mem_rdata (mem_rdata),
                .app_ack   (app_ack),
                .app_rdata (app_rdata)
        );

        tm_pri_sch u_tm_pri_sch (
                .clk           (clk),
                .rst_n         (rst_n),
                .sch_req_valid (sch_req_valid),
                .sch_req       (sch_req),
                .app_rd        (app_rd),
                .app_raddr     (app_raddr),
                .app_ack       (app_ack),
                .app_rdata     (app_rdata),
                .sch_rsp_valid (sch_rsp_valid),
                .sch_rsp       (sch_rsp)
        );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tm_sch_tb -Mdir obj_dir -o tm_sch_sim

sim_out="$(./obj_dir/tm_sch_sim)"
echo "$sim_out"

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
        exit 0
else
        exit 1
fi
